//--- rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

    // Primary opcodes, IR[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_BEQ     = 6'h04,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_e;

    // R-type function codes, IR[5:0]
    typedef enum logic [5:0] {
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2A
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI
    } aluOp_e;

    typedef enum logic [3:0] {
        FETCH_ADDR,
        FETCH_WAIT,
        DECODE,
        EXEC_WB,
        BRANCH,
        MEM_ADDR,
        LOAD_WAIT,
        LOAD_WB,
        STORE_WAIT
    } ctrlState_e;

    // Branch mode is sign extend then word offset
    typedef enum logic [1:0] {
        EXT_SIGN,
        EXT_ZERO,
        EXT_BRANCH
    } extMode_e;

    // Select encodings, a zero picks the first source
    // aSel PC/regA, bSel regB/imm, marSel PC/ALU, mdrSel mem/regB
    // nPcSel inc/target, dstSel rd/rt, wbSel ALU/MDR
    typedef struct packed {
        logic     irLd;
        logic     pcLd;
        logic     nPcLd;
        logic     marLd;
        logic     mdrLd;
        logic     rfLd;
        logic     aSel;
        logic     bSel;
        logic     marSel;
        logic     mdrSel;
        logic     nPcSel;
        logic     dstSel;
        logic     wbSel;
        extMode_e extMode;
        aluOp_e   aluOp;
    } dpCtrl_t;

    typedef struct packed {
        opcode_e opcode;
        funct_e  funct;
    } instrInfo_t;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

//--- rtl/registerFile.sv
`timescale 1ns/1ps
`default_nettype none

module registerFile (
    input  wire logic        clk,
    input  wire logic        arstN_i,
    input  wire logic [4:0]  rdAddrA_i,
    input  wire logic [4:0]  rdAddrB_i,
    input  wire logic [4:0]  wrAddr_i,
    input  wire logic [31:0] wrData_i,
    input  wire logic        wrEn_i,
    output logic      [31:0] rdDataA_o,
    output logic      [31:0] rdDataB_o
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn_i && (wrAddr_i != 5'd0)) begin
            regs[wrAddr_i] <= wrData_i;
        end
    end

    // Register 0 always reads as zero
    always_comb begin
        rdDataA_o = (rdAddrA_i == 5'd0) ? 32'd0 : regs[rdAddrA_i];
        rdDataB_o = (rdAddrB_i == 5'd0) ? 32'd0 : regs[rdAddrB_i];
    end

endmodule

`default_nettype wire

//--- rtl/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire cpuPkg::aluOp_e  op_i,
    input  wire logic     [31:0] a_i,
    input  wire logic     [31:0] b_i,
    output logic          [31:0] result_o,
    output logic                 zero_o
);

    logic lessThan;

    // Signed compare for SLT
    assign lessThan = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            cpuPkg::ALU_ADD: begin
                result_o = a_i + b_i;
            end
            cpuPkg::ALU_SUB: begin
                result_o = a_i - b_i;
            end
            cpuPkg::ALU_AND: begin
                result_o = a_i & b_i;
            end
            cpuPkg::ALU_OR: begin
                result_o = a_i | b_i;
            end
            cpuPkg::ALU_SLT: begin
                result_o = {31'd0, lessThan};
            end
            // Upper immediate, B moved to the high half
            cpuPkg::ALU_LUI: begin
                result_o = b_i << 16;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

    // BEQ compares through SUB and looks at this flag
    assign zero_o = (result_o == 32'd0);

endmodule

`default_nettype wire

//--- rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
    input  wire logic               clk,
    input  wire logic               arstN_i,
    input  wire cpuPkg::instrInfo_t instr_i,
    input  wire logic               aluZero_i,
    input  wire logic               memDone_i,
    output cpuPkg::dpCtrl_t         ctrl_o,
    output logic                    memRead_o,
    output logic                    memWrite_o
);

    cpuPkg::ctrlState_e state;
    cpuPkg::ctrlState_e nextState;

    // Decoded operation, valid once IR holds the instruction
    cpuPkg::aluOp_e   decAluOp;
    cpuPkg::extMode_e decExt;
    logic             decImm;
    logic             decDstRt;
    logic             decWrite;

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            state <= cpuPkg::FETCH_ADDR;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        decAluOp = cpuPkg::ALU_ADD;
        decExt   = cpuPkg::EXT_SIGN;
        decImm   = 1'b1;
        decDstRt = 1'b1;
        decWrite = 1'b1;
        case (instr_i.opcode)
            cpuPkg::OP_SPECIAL: begin
                decImm   = 1'b0;
                decDstRt = 1'b0;
                case (instr_i.funct)
                    cpuPkg::FN_ADDU: decAluOp = cpuPkg::ALU_ADD;
                    cpuPkg::FN_SUBU: decAluOp = cpuPkg::ALU_SUB;
                    cpuPkg::FN_AND:  decAluOp = cpuPkg::ALU_AND;
                    cpuPkg::FN_OR:   decAluOp = cpuPkg::ALU_OR;
                    cpuPkg::FN_SLT:  decAluOp = cpuPkg::ALU_SLT;
                    default:         decWrite = 1'b0;
                endcase
            end
            cpuPkg::OP_ADDIU: begin
                decAluOp = cpuPkg::ALU_ADD;
            end
            cpuPkg::OP_ORI: begin
                decAluOp = cpuPkg::ALU_OR;
                decExt   = cpuPkg::EXT_ZERO;
            end
            cpuPkg::OP_LUI: begin
                decAluOp = cpuPkg::ALU_LUI;
                decExt   = cpuPkg::EXT_ZERO;
            end
            // Base plus offset, written back only from LOAD_WB
            cpuPkg::OP_LW, cpuPkg::OP_SW: begin
                decWrite = 1'b0;
            end
            // Compare rs with rt, offset goes to the target adder
            cpuPkg::OP_BEQ: begin
                decAluOp = cpuPkg::ALU_SUB;
                decExt   = cpuPkg::EXT_BRANCH;
                decImm   = 1'b0;
                decWrite = 1'b0;
            end
            default: begin
                decWrite = 1'b0;
            end
        endcase
    end

    always_comb begin
        ctrl_o         = '0;
        ctrl_o.aluOp   = decAluOp;
        ctrl_o.extMode = decExt;
        ctrl_o.aSel    = 1'b1;
        ctrl_o.bSel    = decImm;
        ctrl_o.dstSel  = decDstRt;
        memRead_o      = 1'b0;
        memWrite_o     = 1'b0;
        nextState      = state;
        case (state)
            cpuPkg::FETCH_ADDR: begin
                ctrl_o.marLd = 1'b1;
                nextState    = cpuPkg::FETCH_WAIT;
            end
            cpuPkg::FETCH_WAIT: begin
                memRead_o   = 1'b1;
                ctrl_o.irLd = memDone_i;
                if (memDone_i) begin
                    nextState = cpuPkg::DECODE;
                end
            end
            // PC steps into the delay slot here
            cpuPkg::DECODE: begin
                ctrl_o.pcLd  = 1'b1;
                ctrl_o.nPcLd = 1'b1;
                case (instr_i.opcode)
                    cpuPkg::OP_BEQ:             nextState = cpuPkg::BRANCH;
                    cpuPkg::OP_LW, cpuPkg::OP_SW: nextState = cpuPkg::MEM_ADDR;
                    default:                    nextState = cpuPkg::EXEC_WB;
                endcase
            end
            cpuPkg::EXEC_WB: begin
                ctrl_o.rfLd = decWrite;
                nextState   = cpuPkg::FETCH_ADDR;
            end
            cpuPkg::BRANCH: begin
                ctrl_o.nPcSel = 1'b1;
                ctrl_o.nPcLd  = aluZero_i;
                nextState     = cpuPkg::FETCH_ADDR;
            end
            cpuPkg::MEM_ADDR: begin
                ctrl_o.marLd  = 1'b1;
                ctrl_o.marSel = 1'b1;
                if (instr_i.opcode == cpuPkg::OP_SW) begin
                    ctrl_o.mdrLd  = 1'b1;
                    ctrl_o.mdrSel = 1'b1;
                    nextState     = cpuPkg::STORE_WAIT;
                end else begin
                    nextState = cpuPkg::LOAD_WAIT;
                end
            end
            cpuPkg::LOAD_WAIT: begin
                memRead_o    = 1'b1;
                ctrl_o.mdrLd = memDone_i;
                if (memDone_i) begin
                    nextState = cpuPkg::LOAD_WB;
                end
            end
            cpuPkg::LOAD_WB: begin
                ctrl_o.rfLd   = 1'b1;
                ctrl_o.wbSel  = 1'b1;
                ctrl_o.dstSel = 1'b1;
                nextState     = cpuPkg::FETCH_ADDR;
            end
            cpuPkg::STORE_WAIT: begin
                memWrite_o = 1'b1;
                if (memDone_i) begin
                    nextState = cpuPkg::FETCH_ADDR;
                end
            end
            default: begin
                nextState = cpuPkg::FETCH_ADDR;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/dataPath.sv
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
    parameter int MEM_AW = 32
) (
    input  wire logic                  clk,
    input  wire logic                  arstN_i,
    input  wire cpuPkg::dpCtrl_t       ctrl_i,
    input  wire logic           [31:0] memRData_i,
    output cpuPkg::instrInfo_t         instr_o,
    output logic                       aluZero_o,
    output logic          [MEM_AW-1:0] memAddr_o,
    output logic                [31:0] memWData_o
);

    logic [31:0] pc;
    logic [31:0] nPc;
    logic [31:0] ir;
    logic [31:0] mar;
    logic [31:0] mdr;

    logic [31:0] rdDataA;
    logic [31:0] rdDataB;
    logic [31:0] aluA;
    logic [31:0] aluB;
    logic [31:0] aluResult;
    logic [31:0] extImm;
    logic [31:0] nPcInc;
    logic [31:0] branchTarget;
    logic [31:0] nPcNext;
    logic [31:0] marNext;
    logic [31:0] mdrNext;
    logic [31:0] wbData;
    logic [4:0]  wrAddr;

    // IR fields
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;

    assign rs  = ir[25:21];
    assign rt  = ir[20:16];
    assign rd  = ir[15:11];
    assign imm = ir[15:0];

    always_comb begin
        instr_o.opcode = cpuPkg::opcode_e'(ir[31:26]);
        instr_o.funct  = cpuPkg::funct_e'(ir[5:0]);
    end

    // Architectural program counters
    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pc  <= cpuPkg::RESET_PC;
            nPc <= cpuPkg::RESET_PC + 32'd4;
        end else begin
            if (ctrl_i.pcLd) begin
                pc <= nPc;
            end
            if (ctrl_i.nPcLd) begin
                nPc <= nPcNext;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl_i.irLd) begin
            ir <= memRData_i;
        end
        if (ctrl_i.marLd) begin
            mar <= marNext;
        end
        if (ctrl_i.mdrLd) begin
            mdr <= mdrNext;
        end
    end

    // Immediate extender
    always_comb begin
        case (ctrl_i.extMode)
            cpuPkg::EXT_ZERO:   extImm = {16'd0, imm};
            cpuPkg::EXT_BRANCH: extImm = {{14{imm[15]}}, imm, 2'b00};
            default:            extImm = {{16{imm[15]}}, imm};
        endcase
    end

    // Sequential and branch adders; PC already points at the delay slot
    assign nPcInc       = nPc + 32'd4;
    assign branchTarget = pc + extImm;
    assign nPcNext      = ctrl_i.nPcSel ? branchTarget : nPcInc;

    assign aluA    = ctrl_i.aSel ? rdDataA : pc;
    assign aluB    = ctrl_i.bSel ? extImm : rdDataB;
    assign marNext = ctrl_i.marSel ? aluResult : pc;
    assign mdrNext = ctrl_i.mdrSel ? rdDataB : memRData_i;

    // rt for immediates and loads, rd for R-type
    assign wrAddr = ctrl_i.dstSel ? rt : rd;
    assign wbData = ctrl_i.wbSel ? mdr : aluResult;

    registerFile regFile (
        .clk       (clk),
        .arstN_i   (arstN_i),
        .rdAddrA_i (rs),
        .rdAddrB_i (rt),
        .wrAddr_i  (wrAddr),
        .wrData_i  (wbData),
        .wrEn_i    (ctrl_i.rfLd),
        .rdDataA_o (rdDataA),
        .rdDataB_o (rdDataB)
    );

    alu aluUnit (
        .op_i     (ctrl_i.aluOp),
        .a_i      (aluA),
        .b_i      (aluB),
        .result_o (aluResult),
        .zero_o   (aluZero_o)
    );

    assign memAddr_o  = mar[MEM_AW-1:0];
    assign memWData_o = mdr;

endmodule

`default_nettype wire

//--- rtl/cpuCore.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCore #(
    parameter int MEM_AW = 32
) (
    input  wire logic              clk,
    input  wire logic              arstN_i,
    input  wire logic       [31:0] memRData_i,
    input  wire logic              memDone_i,
    output logic      [MEM_AW-1:0] memAddr_o,
    output logic            [31:0] memWData_o,
    output logic                   memRead_o,
    output logic                   memWrite_o
);

    cpuPkg::dpCtrl_t    ctrl;
    cpuPkg::instrInfo_t instrInfo;
    logic               aluZero;

    controlUnit ctrlUnit (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .instr_i    (instrInfo),
        .aluZero_i  (aluZero),
        .memDone_i  (memDone_i),
        .ctrl_o     (ctrl),
        .memRead_o  (memRead_o),
        .memWrite_o (memWrite_o)
    );

    dataPath #(
        .MEM_AW (MEM_AW)
    ) dPath (
        .clk        (clk),
        .arstN_i    (arstN_i),
        .ctrl_i     (ctrl),
        .memRData_i (memRData_i),
        .instr_o    (instrInfo),
        .aluZero_o  (aluZero),
        .memAddr_o  (memAddr_o),
        .memWData_o (memWData_o)
    );

endmodule

`default_nettype wire

//--- dv/cpuCoreAssert.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreAssert (
    input wire logic clk,
    input wire logic arstN_i,
    input wire logic memRead_i,
    input wire logic memWrite_i,
    input wire logic memDone_i
);

    // One request kind at a time
    strobeExclusive: assert property (@(posedge clk) disable iff (!arstN_i)
        !(memRead_i && memWrite_i))
        else $error("memRead_o and memWrite_o are high together");

    readHeld: assert property (@(posedge clk) disable iff (!arstN_i)
        (memRead_i && !memDone_i) |=> memRead_i)
        else $error("memRead_o dropped before memDone_i");

    writeHeld: assert property (@(posedge clk) disable iff (!arstN_i)
        (memWrite_i && !memDone_i) |=> memWrite_i)
        else $error("memWrite_o dropped before memDone_i");

    idleInReset: assert property (@(posedge clk)
        !arstN_i |-> (!memRead_i && !memWrite_i))
        else $error("memory strobe high during reset");

endmodule

bind cpuCore cpuCoreAssert strobeChecks (
    .clk        (clk),
    .arstN_i    (arstN_i),
    .memRead_i  (memRead_o),
    .memWrite_i (memWrite_o),
    .memDone_i  (memDone_i)
);

`default_nettype wire

//--- dv/isaModel.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// MIPS primary opcodes and function codes
localparam logic [5:0] OPC_SPECIAL = 6'h00;
localparam logic [5:0] OPC_BEQ     = 6'h04;
localparam logic [5:0] OPC_ADDIU   = 6'h09;
localparam logic [5:0] OPC_ORI     = 6'h0D;
localparam logic [5:0] OPC_LUI     = 6'h0F;
localparam logic [5:0] OPC_LW      = 6'h23;
localparam logic [5:0] OPC_SW      = 6'h2B;
localparam logic [5:0] FUN_ADDU    = 6'h21;
localparam logic [5:0] FUN_SUBU    = 6'h23;
localparam logic [5:0] FUN_AND     = 6'h24;
localparam logic [5:0] FUN_OR      = 6'h25;
localparam logic [5:0] FUN_SLT     = 6'h2A;

// Data access expected after the last fetch
typedef struct packed {
    logic        valid;
    logic        write;
    logic [31:0] addr;
    logic [31:0] data;
} memAccess_t;

logic [31:0] mRegs [32];
logic [31:0] mPc;
logic [31:0] mNpc;

function automatic logic [31:0] encR(input logic [5:0] funct, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [4:0] rd);
    return {OPC_SPECIAL, rs, rt, rd, 5'd0, funct};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic void modelReset();
    for (int r = 0; r < 32; r++) begin
        mRegs[r] = 32'd0;
    end
    mPc  = cpuPkg::RESET_PC;
    mNpc = cpuPkg::RESET_PC + 32'd4;
endfunction

// Executes one instruction; LW reads the testbench memory directly
function automatic memAccess_t modelStep(input logic [31:0] instr);
    memAccess_t  acc;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] sImm;
    logic [31:0] res;
    logic [31:0] nextNpc;
    logic [4:0]  dst;
    logic        wr;
    acc     = '0;
    a       = mRegs[instr[25:21]];
    b       = mRegs[instr[20:16]];
    sImm    = {{16{instr[15]}}, instr[15:0]};
    res     = 32'd0;
    nextNpc = mNpc + 32'd4;
    dst     = instr[20:16];
    wr      = 1'b1;
    case (instr[31:26])
        OPC_SPECIAL: begin
            dst = instr[15:11];
            case (instr[5:0])
                FUN_ADDU: res = a + b;
                FUN_SUBU: res = a - b;
                FUN_AND:  res = a & b;
                FUN_OR:   res = a | b;
                FUN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                default:  wr = 1'b0;
            endcase
        end
        OPC_ADDIU: res = a + sImm;
        OPC_ORI:   res = a | {16'd0, instr[15:0]};
        OPC_LUI:   res = {instr[15:0], 16'd0};
        OPC_LW: begin
            acc.valid = 1'b1;
            acc.addr  = a + sImm;
            res       = mem[acc.addr[10:2]];
        end
        OPC_SW: begin
            wr        = 1'b0;
            acc.valid = 1'b1;
            acc.write = 1'b1;
            acc.addr  = a + sImm;
            acc.data  = b;
        end
        // Target counts from the delay slot
        OPC_BEQ: begin
            wr = 1'b0;
            if (a == b) begin
                nextNpc = mNpc + {sImm[29:0], 2'b00};
            end
        end
        default: wr = 1'b0;
    endcase
    if (wr && dst != 5'd0) begin
        mRegs[dst] = res;
    end
    mPc  = mNpc;
    mNpc = nextNpc;
    return acc;
endfunction

`endif

//--- dv/cpuCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

    localparam int MEM_AW       = 32;
    localparam int MEM_WORDS    = 512;
    localparam int BODY_LEN     = 48;
    localparam int PROG_LEN     = BODY_LEN + 34;
    localparam int NUM_TESTS    = 5;
    localparam int RESET_CYCLES = 4;
    // Worst instruction path stays under 16 cycles
    localparam int CYCLE_LIMIT  = NUM_TESTS * (PROG_LEN * 16 + RESET_CYCLES + 2);
    localparam logic [31:0] LOOP_ADDR = cpuPkg::RESET_PC + 32'((BODY_LEN + 32) * 4);

    logic              clk;
    logic              arstN;
    logic       [31:0] memRData;
    logic              memDone;
    logic [MEM_AW-1:0] memAddr;
    logic       [31:0] memWData;
    logic              memRead;
    logic              memWrite;

    logic [31:0] mem [MEM_WORDS];
    logic        expectFetch;
    logic        testDone;
    logic        busy;
    int          waitLeft;
    int          cycleCount = 0;
    int          errorCount = 0;
    int          checkCount = 0;
    int          fetchCount;
    int          storeCount;

    `include "isaModel.svh"

    memAccess_t  pendingAcc;

    cpuCore #(
        .MEM_AW (MEM_AW)
    ) dut_i (
        .clk        (clk),
        .arstN_i    (arstN),
        .memRData_i (memRData),
        .memDone_i  (memDone),
        .memAddr_o  (memAddr),
        .memWData_o (memWData),
        .memRead_o  (memRead),
        .memWrite_o (memWrite)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: the program did not reach its final loop in %0d cycles",
                     CYCLE_LIMIT);
            $display("*** FAILED ***");
            $finish;
        end
    end

    task automatic checkEq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("MISMATCH at %0t: %s expected %08h actual %08h",
                     $time, name, expected, actual);
        end
    endtask

    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        return (addr * 32'h9E37_79B1) ^ 32'h5A5A_0F0F;
    endfunction

    // Instruction classes 0 R-type, 1 immediate, 2 load/store, 3 BEQ, 4 unsupported
    function automatic logic [31:0] randInstr(input int mode, input int idx, input logic afterBeq);
        int          kind;
        int          cls;
        int          room;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [15:0] imm;
        logic [5:0]  op;
        rs   = 5'($urandom_range(31, 0));
        rt   = 5'($urandom_range(31, 0));
        rd   = 5'($urandom_range(31, 0));
        imm  = 16'($urandom);
        kind = int'($urandom_range(99, 0));
        room = BODY_LEN - 1 - idx;
        case (mode)
            0: cls = (kind < 50) ? 0 : 1;
            1: cls = (kind < 30) ? 0 : (kind < 55) ? 1 : 2;
            2: cls = (kind < 30) ? 0 : (kind < 60) ? 1 : 3;
            3: cls = (kind < 30) ? 0 : (kind < 60) ? 1 : 4;
            default: cls = kind / 20;
        endcase
        // No branch in a delay slot or past the body
        if (cls == 3 && (afterBeq || room < 1)) begin
            cls = 1;
        end
        case (cls)
            0: begin
                case ($urandom_range(4, 0))
                    0: return encR(FUN_ADDU, rs, rt, rd);
                    1: return encR(FUN_SUBU, rs, rt, rd);
                    2: return encR(FUN_AND, rs, rt, rd);
                    3: return encR(FUN_OR, rs, rt, rd);
                    default: return encR(FUN_SLT, rs, rt, rd);
                endcase
            end
            1: begin
                case ($urandom_range(2, 0))
                    0: return encI(OPC_ADDIU, rs, rt, imm);
                    1: return encI(OPC_ORI, rs, rt, imm);
                    default: return encI(OPC_LUI, 5'd0, rt, imm);
                endcase
            end
            2: begin
                op  = ($urandom_range(1, 0) == 1) ? OPC_LW : OPC_SW;
                imm = 16'(32'h400 + 4 * $urandom_range(255, 0));
                return encI(op, 5'd0, rt, imm);
            end
            3: begin
                if ($urandom_range(1, 0) == 1) begin
                    rt = rs;
                end
                imm = 16'($urandom_range((room < 3) ? room : 3, 1));
                return encI(OPC_BEQ, rs, rt, imm);
            end
            default: begin
                case ($urandom_range(5, 0))
                    0: return encI(6'h02, rs, rt, imm);
                    1: return encI(6'h08, rs, rt, imm);
                    2: return encI(6'h0A, rs, rt, imm);
                    3: return encI(6'h3F, rs, rt, imm);
                    4: return encR(6'h22, rs, rt, rd);
                    default: return encR(6'h00, rs, rt, rd);
                endcase
            end
        endcase
    endfunction

    task automatic loadProgram(input int mode);
        int   base;
        logic beqPrev;
        base    = int'(cpuPkg::RESET_PC[10:2]);
        beqPrev = 1'b0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fillWord(32'(i * 4));
        end
        for (int i = 0; i < BODY_LEN; i++) begin
            mem[base + i] = randInstr(mode, i, beqPrev);
            beqPrev = (mem[base + i][31:26] == OPC_BEQ);
        end
        // Register dump, then a self-loop with a no-op delay slot
        for (int r = 0; r < 32; r++) begin
            mem[base + BODY_LEN + r] = encI(OPC_SW, 5'd0, 5'(r), 16'(32'h700 + r * 4));
        end
        mem[base + BODY_LEN + 32] = encI(OPC_BEQ, 5'd0, 5'd0, 16'hFFFF);
        mem[base + BODY_LEN + 33] = 32'd0;
    endtask

    task automatic serviceAccess();
        logic [31:0] addr;
        memAccess_t  acc;
        addr = 32'(memAddr);
        if (addr[31:11] != '0 || addr[1:0] != 2'b00) begin
            errorCount++;
            $display("Error at %0t: access to %08h is outside the word memory", $time, addr);
        end else if (expectFetch) begin
            checkEq("memRead_o (fetch)", 32'd1, {31'd0, memRead});
            checkEq("memWrite_o (fetch)", 32'd0, {31'd0, memWrite});
            checkEq("memAddr_o (fetch)", mPc, addr);
            fetchCount++;
            if (mPc == LOOP_ADDR) begin
                testDone = 1'b1;
            end
            memRData <= mem[addr[10:2]];
            acc = modelStep(mem[mPc[10:2]]);
            pendingAcc  = acc;
            expectFetch = !acc.valid;
        end else begin
            checkEq("memRead_o (data)", {31'd0, ~pendingAcc.write}, {31'd0, memRead});
            checkEq("memWrite_o (data)", {31'd0, pendingAcc.write}, {31'd0, memWrite});
            checkEq("memAddr_o (data)", pendingAcc.addr, addr);
            if (memWrite) begin
                checkEq("memWData_o", pendingAcc.data, memWData);
                mem[addr[10:2]] = memWData;
                storeCount++;
            end else begin
                memRData <= mem[addr[10:2]];
            end
            expectFetch = 1'b1;
        end
    endtask

    // Memory answers each request after 1 to 4 cycles
    always @(negedge clk) begin
        memDone <= 1'b0;
        if (!arstN) begin
            busy = 1'b0;
        end else if (memRead || memWrite) begin
            if (!busy) begin
                busy     = 1'b1;
                waitLeft = int'($urandom_range(3, 0));
            end
            if (waitLeft == 0) begin
                serviceAccess();
                memDone <= 1'b1;
                busy = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    task automatic runReset(input int mode);
        @(negedge clk);
        arstN <= 1'b0;
        @(negedge clk);
        loadProgram(mode);
        modelReset();
        pendingAcc  = '0;
        expectFetch = 1'b1;
        testDone    = 1'b0;
        fetchCount  = 0;
        storeCount  = 0;
        repeat (RESET_CYCLES - 1) @(negedge clk);
        arstN <= 1'b1;
    endtask

    function automatic string testName(input int mode);
        case (mode)
            0: return "sequential fetch and ALU";
            1: return "loads and stores";
            2: return "BEQ with delay slot";
            3: return "unsupported opcodes";
            default: return "full mix";
        endcase
    endfunction

    initial begin
        int errBefore;
        void'($urandom(32'h823bda51));
        clk      = 1'b0;
        arstN    = 1'b0;
        memRData = 32'd0;
        memDone  = 1'b0;
        busy     = 1'b0;
        waitLeft = 0;
        testDone = 1'b0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            errBefore = errorCount;
            runReset(t);
            wait (testDone);
            $display("Test %0d %s: %0d fetches, %0d stores, %0d errors",
                     t, testName(t), fetchCount, storeCount, errorCount - errBefore);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors",
                 NUM_TESTS, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+dv
rtl/cpuPkg.sv
rtl/registerFile.sv
rtl/alu.sv
rtl/controlUnit.sv
rtl/dataPath.sv
rtl/cpuCore.sv
dv/cpuCoreAssert.sv
dv/cpuCoreTb.sv

//--- Makefile
SIM      ?= verilator
SIMFLAGS ?= --binary --assert --timescale 1ns/1ps -Wno-fatal
TOP      ?= cpuCoreTb
FILELIST ?= build.f
OBJDIR   ?= obj_dir

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard dv/*.svh)
BINARY  := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: $(BINARY)

$(BINARY): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: $(BINARY)
	@out="$$(./$(BINARY))"; echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJDIR)
